// File: src.f
common/ahb_axi_pkg.sv
ahb_slave/ahb_bus_fsm.sv
ahb_slave/ahb_addr_check.sv
rtl/axi_cmd_buffer.sv
rtl/ahb_to_axi4.sv
test/ahb_to_axi4_sva.sv
test/tb_ahb_to_axi4.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ahb_to_axi4 -f src.f -o sim_tb
out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"
echo "$out" | grep -q "^STATUS: PASS$"

// File: test/tb_ahb_to_axi4.sv
module tb_ahb_to_axi4;
   timeunit 1ns;
   timeprecision 1ps;
   import ahb_axi_pkg::*;

   localparam int n_xfers    = 27;                          // Transfers issued by all tests
   localparam int max_cycles = 40 * n_xfers;
   localparam logic [addr_w-1:0] err_addr = 32'h2000_8f00;  // Slave answers SLVERR here

   logic clk, rst_n, hwrite, hsel, hreadyin, hreadyout, hresp;
   logic [addr_w-1:0] haddr, awaddr, araddr;
   logic [2:0] hsize, awsize, arsize;
   logic [1:0] htrans, rresp;
   logic [data_w-1:0] hwdata, hrdata, wdata, rdata, last_rdata;
   logic awvalid, awready, wvalid, wready, arvalid, arready, rvalid;
   logic [strb_w-1:0] wstrb;

   logic [31:0] rnd_state = 32'd75675;
   logic [data_w-1:0] slave_mem [logic [addr_w-1:0]];       // AXI slave storage
   logic [data_w-1:0] shadow [logic [addr_w-1:0]];          // Master side expectation
   logic [addr_w-1:0] exp_addr[$];
   logic [2:0] exp_size[$];
   logic [data_w-1:0] exp_data[$];
   logic [addr_w-1:0] exp_rd_addr[$];                       // Reads due on AR
   logic [2:0] exp_rd_size[$];
   logic [addr_w-1:0] wr_addrs [8];
   int errors = 0, tests = 0, failed = 0, test_start = 0, cycles = 0;

   ahb_to_axi4 uut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      rnd_state ^= rnd_state << 13;
      rnd_state ^= rnd_state >> 17;
      rnd_state ^= rnd_state << 5;
      return rnd_state;
   endfunction

   function automatic logic [data_w-1:0] fill_word(input logic [addr_w-1:0] a);
      return {a ^ 32'h5a5a_a5a5, ~a};                         // Unwritten memory
   endfunction

   function automatic logic [strb_w-1:0] lane_mask(input logic [2:0] sz, input logic [2:0] lane);
      case (sz)
         size_byte: return 8'h01 << lane;
         size_half: return 8'h03 << lane;
         size_word: return 8'h0f << lane;
         default:   return 8'hff;
      endcase
   endfunction

   function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_w,
         input logic [data_w-1:0] new_w, input logic [strb_w-1:0] strb);
      logic [data_w-1:0] res;
      res = old_w;
      for (int i = 0; i < strb_w; i++) begin
         if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
      end
      return res;
   endfunction

   // ************************************************************************
   // AXI slave responder
   // ************************************************************************
   initial begin
      logic [addr_w-1:0] key, rd_addr, ea, ra;
      logic [data_w-1:0] ed;
      logic [2:0] es, rs;
      logic [31:0] r;
      logic rd_open;
      int rd_wait;
      rd_open = 1'b0;
      rd_wait = 0;
      rd_addr = '0;
      forever begin
         @(posedge clk);
         if (rst_n && awvalid && awready) begin
            if (exp_addr.size() == 0) begin
               $display("unexpected AXI write command at %0t", $time);
               errors++;
            end else begin
               ea = exp_addr.pop_front();
               es = exp_size.pop_front();
               ed = exp_data.pop_front();
               assert (awaddr == ea && awsize == es && wdata == ed &&
                       wstrb == lane_mask(es, ea[2:0]))
                  else begin
                     $display("mismatch at %0t: write %h/%0d/%h/%h", $time, awaddr, awsize,
                              wdata, wstrb);
                     errors++;
                  end
            end
            key = {awaddr[addr_w-1:3], 3'b000};
            slave_mem[key] = merge_bytes(slave_mem.exists(key) ? slave_mem[key] :
                                         fill_word(key), wdata, wstrb);
         end
         if (rst_n && arvalid && arready) begin
            if (exp_rd_addr.size() == 0) begin
               $display("unexpected AXI read command at %0t", $time);
               errors++;
            end else begin
               ra = exp_rd_addr.pop_front();
               rs = exp_rd_size.pop_front();
               assert (araddr == ra && arsize == rs) else begin
                  $display("mismatch at %0t: read %h/%0d, expected %h/%0d", $time, araddr,
                           arsize, ra, rs);
                  errors++;
               end
            end
            rd_open = 1'b1;
            rd_addr = {araddr[addr_w-1:3], 3'b000};
            rd_wait = int'(next_rand() % 32'd4);              // Random read latency
         end
         @(negedge clk);
         r = next_rand();
         awready = (r[1:0] == 2'd0);                        // Mostly stalls writes
         wready  = awready;
         arready = (r[3:2] != 2'd0);
         rvalid  = 1'b0;
         rresp   = resp_okay;
         if (rd_open && rd_wait == 0) begin
            rvalid     = 1'b1;
            rdata      = slave_mem.exists(rd_addr) ? slave_mem[rd_addr] : fill_word(rd_addr);
            rresp      = (rd_addr == err_addr) ? 2'b10 : resp_okay;
            last_rdata = rdata;
            rd_open    = 1'b0;
         end else if (rd_open) begin
            rd_wait--;
         end
      end
   end

   // ************************************************************************
   // AHB master
   // ************************************************************************
   // kind 0 legal, 1 address error, 2 read error from the slave
   task automatic ahb_xfer(input logic wr, input logic [addr_w-1:0] a, input logic [2:0] sz,
                           input logic [data_w-1:0] d, input int kind);
      logic [addr_w-1:0] key;
      logic [data_w-1:0] expect_rd;
      logic err_seen, cmd_seen;
      key = {a[addr_w-1:3], 3'b000};
      err_seen = 1'b0;
      cmd_seen = 1'b0;
      hsel = 1'b1;
      htrans = htrans_nonseq;
      haddr = a;
      hsize = sz;
      hwrite = wr;
      @(posedge clk);
      while (!hreadyout) @(posedge clk);                    // Address phase accepted
      @(negedge clk);
      hsel = 1'b0;
      htrans = htrans_idle;
      hwdata = d;
      if (wr && kind == 0) begin
         exp_addr.push_back(a);
         exp_size.push_back(sz);
         exp_data.push_back(d);
         shadow[key] = merge_bytes(shadow.exists(key) ? shadow[key] : fill_word(key), d,
                                   lane_mask(sz, a[2:0]));
      end
      if (!wr && kind != 1) begin
         exp_rd_addr.push_back(a);                          // Legal address goes out on AR
         exp_rd_size.push_back(sz);
      end
      expect_rd = shadow.exists(key) ? shadow[key] : fill_word(key);
      forever begin
         @(posedge clk);
         if (awvalid || arvalid) cmd_seen = 1'b1;
         if (wr && kind == 0 && awvalid && !awready)
            assert (!hreadyout) else begin
               $display("mismatch at %0t: write data phase done with full buffer", $time);
               errors++;
            end
         if (hresp && !hreadyout) err_seen = 1'b1;
         if (hreadyout) break;
      end
      if (kind == 0) begin
         assert (!hresp && (wr || (hrdata == expect_rd && hrdata == last_rdata)))
            else begin
               $display("mismatch at %0t: %h hresp %b hrdata %h model %h", $time, a, hresp,
                        hrdata, expect_rd);
               errors++;
            end
      end else begin
         assert (hresp && err_seen) else begin
            $display("mismatch at %0t: no two-cycle error for %h", $time, a);
            errors++;
         end
         if (kind == 1 && cmd_seen) begin
            $display("an AXI command was issued for bad address %h", a);
            errors++;
         end
      end
      @(negedge clk);
   endtask

   task automatic drain_cmds();
      while (awvalid || arvalid) @(negedge clk);
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == test_start) begin
         $display("test %s ok", name);
      end else begin
         $display("test %s failed", name);
         failed++;
      end
      test_start = errors;
   endtask

   initial begin
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > max_cycles) begin
            $display("timeout after %0d cycles, a transfer never finished", cycles);
            $display("STATUS: FAIL");
            $finish;
         end
      end
   end

   // ************************************************************************
   // Test sequence
   // ************************************************************************
   initial begin
      logic [31:0] r;
      logic [2:0] sz, lane;
      logic [addr_w-1:0] a;
      rst_n = 1'b0;
      haddr = '0;
      hsize = size_word;
      htrans = htrans_idle;
      hwrite = 1'b0;
      hwdata = '0;
      hsel = 1'b0;
      hreadyin = 1'b1;                                      // Single slave bus
      awready = 1'b0;
      wready = 1'b0;
      arready = 1'b0;
      rvalid = 1'b0;
      rdata = '0;
      rresp = resp_okay;
      last_rdata = '0;
      repeat (3) begin
         @(negedge clk);
         assert (!awvalid && !wvalid && !arvalid && !hresp && hreadyout) else begin
            $display("mismatch at %0t: outputs active in reset", $time);
            errors++;
         end
      end
      rst_n = 1'b1;
      @(negedge clk);
      assert (!awvalid && !wvalid && !arvalid && !hresp && hreadyout) else begin
         $display("mismatch at %0t: outputs active after reset", $time);
         errors++;
      end
      end_test("reset");

      for (int i = 0; i < 8; i++) begin
         r = next_rand();
         sz = r[16] ? size_word : size_dword;
         wr_addrs[i] = {mem_base[31:16], 1'b0, r[14:3],
                        (sz == size_word && r[17]) ? 3'b100 : 3'b000};
         ahb_xfer(1'b1, wr_addrs[i], sz, {next_rand(), next_rand()}, 0);
      end
      end_test("write");

      for (int i = 0; i < 8; i++) begin
         r = next_rand();
         sz = {1'b0, r[1:0]};
         lane = r[4:2] & (3'b111 << sz);                    // Natural alignment
         ahb_xfer(1'b0, {wr_addrs[i][31:3], lane}, sz, '0, 0);
      end
      end_test("read");

      for (int i = 0; i < 3; i++) begin
         r = next_rand();
         a = {mem_base[31:16], 1'b0, r[14:3], 3'b000};
         ahb_xfer(1'b1, a, size_dword, {next_rand(), next_rand()}, 0);
         ahb_xfer(1'b0, a, size_dword, '0, 0);              // Waits behind the write
      end
      end_test("wr_then_rd");

      drain_cmds();
      ahb_xfer(1'b0, 32'h3000_0000, size_word, '0, 1);      // Outside the window
      ahb_xfer(1'b1, 32'h2000_0102, size_word, 64'h1, 1);   // Misaligned word
      ahb_xfer(1'b1, 32'h2000_0010, size_byte, 64'h2, 1);   // Narrow write
      ahb_xfer(1'b0, 32'h2000_0021, size_half, '0, 1);      // Misaligned half
      end_test("addr_error");

      ahb_xfer(1'b0, err_addr, size_word, '0, 2);
      end_test("read_error");

      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: test/ahb_to_axi4_sva.sv
module ahb_to_axi4_sva (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             hreadyout,
   input  logic                             hresp,
   input  logic                             awvalid,
   input  logic                             awready,
   input  logic [ahb_axi_pkg::addr_w-1:0]   awaddr,
   input  logic [2:0]                       awsize,
   input  logic                             wvalid,
   input  logic [ahb_axi_pkg::data_w-1:0]   wdata,
   input  logic [ahb_axi_pkg::strb_w-1:0]   wstrb,
   input  logic                             arvalid,
   input  logic                             arready,
   input  logic [ahb_axi_pkg::addr_w-1:0]   araddr,
   input  logic [2:0]                       arsize
);
   timeunit 1ns;
   timeprecision 1ps;

   // Quiet bus in the cycle after a reset edge
   reset_quiet: assert property (@(posedge clk)
      !rst_n |=> (!awvalid && !wvalid && !arvalid && !hresp && hreadyout))
      else $error("bus not idle after reset");

   aw_w_pair: assert property (@(posedge clk) disable iff (!rst_n) awvalid == wvalid)
      else $error("awvalid and wvalid differ");

   // An open read keeps the AHB data phase stalled
   rd_stall: assert property (@(posedge clk) disable iff (!rst_n) arvalid |-> !hreadyout)
      else $error("hreadyout high while a read command waits");

   // Payload frozen while the slave stalls
   aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awsize) &&
                              $stable(wdata) && $stable(wstrb))
      else $error("write command changed before awready");

   ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize))
      else $error("read command changed before arready");

   err_two_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      hresp && !hreadyout |=> hresp && hreadyout)
      else $error("error response not two cycles");

endmodule

bind ahb_to_axi4 ahb_to_axi4_sva u_sva (.*);

// File: rtl/ahb_to_axi4.sv
module ahb_to_axi4 (
   input  logic                             clk,
   input  logic                             rst_n,
   // AHB-Lite slave port
   input  logic [ahb_axi_pkg::addr_w-1:0]   haddr,
   input  logic [2:0]                       hsize,
   input  logic [1:0]                       htrans,
   input  logic                             hwrite,
   input  logic [ahb_axi_pkg::data_w-1:0]   hwdata,
   input  logic                             hsel,
   input  logic                             hreadyin,
   output logic [ahb_axi_pkg::data_w-1:0]   hrdata,
   output logic                             hreadyout,
   output logic                             hresp,
   // AXI write address and data
   output logic                             awvalid,
   input  logic                             awready,
   output logic [ahb_axi_pkg::addr_w-1:0]   awaddr,
   output logic [2:0]                       awsize,
   output logic                             wvalid,
   input  logic                             wready,   // Rises with awready, which completes
   output logic [ahb_axi_pkg::data_w-1:0]   wdata,
   output logic [ahb_axi_pkg::strb_w-1:0]   wstrb,
   // AXI read address and data
   output logic                             arvalid,
   input  logic                             arready,
   output logic [ahb_axi_pkg::addr_w-1:0]   araddr,
   output logic [2:0]                       arsize,
   input  logic                             rvalid,
   input  logic [ahb_axi_pkg::data_w-1:0]   rdata,
   input  logic [1:0]                       rresp
);
   import ahb_axi_pkg::*;

   haddr_u              cap_addr;           // Data phase address
   logic [2:0]          cap_size;
   logic                cap_write;
   logic                addr_err;
   logic [strb_w-1:0]   byte_strb;
   logic                cmd_load;
   logic                cmd_drop;
   logic                cmd_full;
   logic                cmd_write;

   ahb_bus_fsm u_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .haddr     (haddr),
      .hsize     (hsize),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hsel      (hsel),
      .hreadyin  (hreadyin),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .rresp     (rresp),
      .addr_err  (addr_err),
      .cmd_full  (cmd_full),
      .cmd_write (cmd_write),
      .hrdata    (hrdata),
      .hreadyout (hreadyout),
      .hresp     (hresp),
      .cap_addr  (cap_addr),
      .cap_size  (cap_size),
      .cap_write (cap_write),
      .cmd_load  (cmd_load),
      .cmd_drop  (cmd_drop)
   );

   ahb_addr_check u_check (
      .cap_addr  (cap_addr),
      .cap_size  (cap_size),
      .cap_write (cap_write),
      .addr_err  (addr_err),
      .byte_strb (byte_strb)
   );

   axi_cmd_buffer u_cmdbuf (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_load  (cmd_load),
      .cmd_drop  (cmd_drop),
      .cap_addr  (cap_addr),
      .cap_size  (cap_size),
      .cap_write (cap_write),
      .byte_strb (byte_strb),
      .hwdata    (hwdata),
      .awready   (awready),
      .arready   (arready),
      .cmd_full  (cmd_full),
      .cmd_write (cmd_write),
      .awvalid   (awvalid),
      .awaddr    (awaddr),
      .awsize    (awsize),
      .wvalid    (wvalid),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .arvalid   (arvalid),
      .araddr    (araddr),
      .arsize    (arsize)
   );

endmodule

// File: rtl/axi_cmd_buffer.sv
module axi_cmd_buffer (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             cmd_load,
   input  logic                             cmd_drop,
   input  ahb_axi_pkg::haddr_u              cap_addr,
   input  logic [2:0]                       cap_size,
   input  logic                             cap_write,
   input  logic [ahb_axi_pkg::strb_w-1:0]   byte_strb,
   input  logic [ahb_axi_pkg::data_w-1:0]   hwdata,
   input  logic                             awready,
   input  logic                             arready,
   output logic                             cmd_full,
   output logic                             cmd_write,
   output logic                             awvalid,
   output logic [ahb_axi_pkg::addr_w-1:0]   awaddr,
   output logic [2:0]                       awsize,
   output logic                             wvalid,
   output logic [ahb_axi_pkg::data_w-1:0]   wdata,
   output logic [ahb_axi_pkg::strb_w-1:0]   wstrb,
   output logic                             arvalid,
   output logic [ahb_axi_pkg::addr_w-1:0]   araddr,
   output logic [2:0]                       arsize
);
   import ahb_axi_pkg::*;

   logic                cmd_vld;
   logic                cmd_accept;         // Entry leaves this cycle
   logic [2:0]          cmd_size;
   logic [strb_w-1:0]   cmd_strb;
   logic [addr_w-1:0]   cmd_addr;
   logic [data_w-1:0]   cmd_wdata;

   // Only awready completes a write, wready rises with it
   assign cmd_accept = (awvalid & awready) | (arvalid & arready);
   assign cmd_full   = cmd_vld & ~cmd_accept;  // Lets the next load overlap

   // **************************************************************************
   // Entry control
   // **************************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cmd_vld   <= 1'b0;
         cmd_write <= 1'b0;
      end else begin
         if (cmd_drop) begin
            cmd_vld <= 1'b0;
         end else if (cmd_load) begin
            cmd_vld <= 1'b1;
         end else if (cmd_accept) begin
            cmd_vld <= 1'b0;
         end
         if (cmd_load) begin
            cmd_write <= cap_write;
         end
      end
   end

   // Payload, stable while valid
   always_ff @(posedge clk) begin
      if (cmd_load) begin
         cmd_size  <= cap_size;
         cmd_strb  <= byte_strb;
         cmd_addr  <= cap_addr.flat;
         cmd_wdata <= hwdata;                // Write data phase straight off the bus
      end
   end

   // Write address and data move together
   assign awvalid = cmd_vld & cmd_write;
   assign awaddr  = cmd_addr;
   assign awsize  = cmd_size;
   assign wvalid  = cmd_vld & cmd_write;
   assign wdata   = cmd_wdata;
   assign wstrb   = cmd_strb;

   assign arvalid = cmd_vld & ~cmd_write;
   assign araddr  = cmd_addr;
   assign arsize  = cmd_size;

endmodule

// File: ahb_slave/ahb_addr_check.sv
module ahb_addr_check (
   input  ahb_axi_pkg::haddr_u              cap_addr,
   input  logic [2:0]                       cap_size,
   input  logic                             cap_write,
   output logic                             addr_err,
   output logic [ahb_axi_pkg::strb_w-1:0]   byte_strb
);
   import ahb_axi_pkg::*;

   logic          in_window;
   logic          misaligned;
   logic          narrow_write;
   logic          bad_size;

   // Window tag against the base, the base is size aligned
   assign in_window = (cap_addr.f.tag == mem_base[addr_w-1:mem_size_log2]);

   // Natural alignment per size
   assign misaligned = ((cap_size == size_half)  & cap_addr.f.lane[0]) |
                       ((cap_size == size_word)  & (|cap_addr.f.lane[1:0])) |
                       ((cap_size == size_dword) & (|cap_addr.f.lane));

   // Memory takes only word or doubleword writes
   assign narrow_write = cap_write & (cap_size != size_word) & (cap_size != size_dword);

   assign bad_size = (cap_size > size_dword);  // Wider than the data bus

   assign addr_err = ~in_window | misaligned | narrow_write | bad_size;

   // **************************************************************************
   // Write strobes
   // **************************************************************************
   always_comb begin
      case (cap_size)
         size_byte: byte_strb = strb_w'(8'b0000_0001) << cap_addr.f.lane;
         size_half: byte_strb = strb_w'(8'b0000_0011) << cap_addr.f.lane;
         size_word: byte_strb = strb_w'(8'b0000_1111) << cap_addr.f.lane;
         default:   byte_strb = {strb_w{1'b1}};   // Doubleword covers all lanes
      endcase
   end

endmodule

// File: ahb_slave/ahb_bus_fsm.sv
module ahb_bus_fsm (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [ahb_axi_pkg::addr_w-1:0]   haddr,
   input  logic [2:0]                       hsize,
   input  logic [1:0]                       htrans,
   input  logic                             hwrite,
   input  logic                             hsel,
   input  logic                             hreadyin,
   input  logic                             rvalid,
   input  logic [ahb_axi_pkg::data_w-1:0]   rdata,
   input  logic [1:0]                       rresp,
   input  logic                             addr_err,
   input  logic                             cmd_full,
   input  logic                             cmd_write,
   output logic [ahb_axi_pkg::data_w-1:0]   hrdata,
   output logic                             hreadyout,
   output logic                             hresp,
   output ahb_axi_pkg::haddr_u              cap_addr,
   output logic [2:0]                       cap_size,
   output logic                             cap_write,
   output logic                             cmd_load,
   output logic                             cmd_drop
);
   import ahb_axi_pkg::*;

   bus_state_t              state;
   bus_state_t              nxt_state;
   logic                    state_en;
   logic                    hready;             // Transfer accepted this cycle
   logic                    trans_vld;          // Selected NONSEQ or SEQ
   logic                    hresp_q;
   logic                    hready_q;
   logic                    rdata_en;
   logic                    rd_err_in;
   logic                    rd_err_q;           // One cycle pulse after a bad rresp
   logic [data_w-1:0]       rdata_q;

   assign hready    = hreadyout & hreadyin;
   assign trans_vld = hsel & (htrans != htrans_idle) & (htrans != htrans_busy);

   // **************************************************************************
   // Transfer controller
   // **************************************************************************
   always_comb begin
      nxt_state = st_idle;
      state_en  = 1'b0;
      rdata_en  = 1'b0;
      rd_err_in = 1'b0;
      cmd_load  = 1'b0;
      case (state)
         st_idle: begin
            nxt_state = hwrite ? st_wr : st_rd;
            state_en  = hready & trans_vld;
         end
         st_wr: begin
            // Error or no follow-on transfer ends the burst of writes
            nxt_state = (hresp | ~trans_vld) ? st_idle : (hwrite ? st_wr : st_rd);
            state_en  = ~cmd_full | hresp;
            cmd_load  = ~cmd_full & ~hresp;     // Data phase enters the buffer
         end
         st_rd: begin
            nxt_state = hresp ? st_idle : st_pend;
            state_en  = ~cmd_full | hresp;
            cmd_load  = ~cmd_full & ~hresp;
         end
         st_pend: begin
            nxt_state = st_idle;                // Data shows on hrdata next cycle
            state_en  = rvalid;
            rdata_en  = state_en;
            rd_err_in = state_en & (rresp != resp_okay);
         end
         default: begin
            nxt_state = st_idle;
            state_en  = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
      end else if (state_en) begin
         state <= nxt_state;
      end
   end

   // Address phase capture, payload only
   always_ff @(posedge clk) begin
      if (hready & trans_vld) begin
         cap_addr.flat <= haddr;
         cap_size      <= hsize;
         cap_write     <= hwrite;
      end
   end

   // **************************************************************************
   // Response generation
   // **************************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hresp_q  <= 1'b0;
         hready_q <= 1'b0;
         rd_err_q <= 1'b0;
      end else begin
         hresp_q  <= hresp;
         hready_q <= hready;
         rd_err_q <= rd_err_in;
      end
   end

   // First error cycle from the checker or the read return, second from history
   assign hresp = (((state == st_wr) | (state == st_rd)) & addr_err) |
                  rd_err_q |
                  (hresp_q & ~hready_q);

   // Error holds low for one cycle, else stall on a full buffer or an open read
   assign hreadyout = hresp ? (hresp_q & ~hready_q) :
                      ((~cmd_full | (state == st_idle)) &
                       ~((state == st_rd) | (state == st_pend)));

   // Read return buffer
   always_ff @(posedge clk) begin
      if (rdata_en) begin
         rdata_q <= rdata;
      end
   end

   assign hrdata   = rdata_q;
   assign cmd_drop = hresp & ~cmd_write;      // A failed read never reaches AXI

endmodule

// File: common/ahb_axi_pkg.sv
package ahb_axi_pkg;

   // **************************************************************************
   // Bus widths
   // **************************************************************************
   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = data_w / 8;          // One strobe per byte lane

   // Legal memory window, aligned to its own size
   localparam logic [addr_w-1:0] mem_base = 32'h2000_0000;
   localparam int mem_size_log2 = 16;           // 64 KiB

   // Transfer size codes, same encoding on AHB hsize and AXI axsize
   localparam logic [2:0] size_byte  = 3'd0;
   localparam logic [2:0] size_half  = 3'd1;
   localparam logic [2:0] size_word  = 3'd2;
   localparam logic [2:0] size_dword = 3'd3;

   // AHB htrans codes
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_busy   = 2'b01;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   localparam logic [1:0] resp_okay = 2'b00;   // AXI OKAY

   // Transfer controller states
   typedef enum logic [1:0] {
      st_idle = 2'b00,                          // No transfer in data phase
      st_wr   = 2'b01,                          // Write data phase
      st_rd   = 2'b10,                          // Read command waiting for buffer
      st_pend = 2'b11                           // Read issued, waiting on rvalid
   } bus_state_t;

   // Captured AHB address, flat or split for the window and lane checks
   typedef union packed {
      logic [addr_w-1:0] flat;
      struct packed {
         logic [addr_w-mem_size_log2-1:0] tag;  // Window tag
         logic [mem_size_log2-1:3] offset;      // Doubleword within window
         logic [2:0] lane;                      // Byte lane in the 64-bit word
      } f;
   } haddr_u;

endpackage
